/* design/iagc_pkg.sv */
package iagc_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 12;
    localparam int DEC_W  = 4;

    // status codes keep the values the host side already decodes
    typedef enum logic [3:0] {
        STATUS_RESET     = 4'b0000,
        STATUS_INIT      = 4'b0001,
        STATUS_IDLE      = 4'b0010,
        STATUS_SAMPLE    = 4'b0011,
        STATUS_CMD_PARSE = 4'b0100,
        STATUS_CMD_READ  = 4'b0101,
        STATUS_CMD_ERROR = 4'b0110,
        STATUS_DUMP_MEM  = 4'b0111,
        STATUS_CLEAN_MEM = 4'b1000,
        STATUS_SET_MEM   = 4'b1001,
        STATUS_SET_DEC   = 4'b1010
    } iagc_status_e;

    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_SAMPLE  = 3'd1,
        OP_DUMP    = 3'd2,
        OP_CLEAN   = 3'd3,
        OP_SET_MEM = 3'd4,
        OP_SET_DEC = 3'd5
    } iagc_opcode_e;

    typedef struct packed {
        logic              valid;
        logic              we;     // 0 is a read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } dump_beat_t;

endpackage

/* design/iagc_controller.sv */
`timescale 1ns/1ps

module iagc_controller #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_cmd_valid,
    input  iagc_pkg::iagc_opcode_e      i_cmd,
    input  logic [iagc_pkg::DATA_W-1:0] i_cmd_arg,
    input  logic                        i_sample_done,
    input  logic                        i_clean_done,
    input  logic                        i_dump_done,
    output iagc_pkg::iagc_status_e      o_status,
    output logic [iagc_pkg::ADDR_W-1:0] o_mem_size,
    output logic [iagc_pkg::DEC_W-1:0]  o_decimator,
    output logic                        o_cmd_error
);

    iagc_pkg::iagc_status_e      status;
    iagc_pkg::iagc_status_e      next_status;
    iagc_pkg::iagc_status_e      job;         // running job, IDLE when none
    iagc_pkg::iagc_status_e      next_job;
    logic                        job_done;
    logic                        reject;
    logic [iagc_pkg::ADDR_W-1:0] size_arg;
    logic [iagc_pkg::DEC_W-1:0]  dec_arg;

    always_comb begin
        case (job)
            iagc_pkg::STATUS_SAMPLE:    job_done = i_sample_done;
            iagc_pkg::STATUS_CLEAN_MEM: job_done = i_clean_done;
            iagc_pkg::STATUS_DUMP_MEM:  job_done = i_dump_done;
            default:                    job_done = 1'b0;
        endcase
    end

    assign reject = i_cmd_valid && i_cmd != iagc_pkg::OP_NOP
                    && status != iagc_pkg::STATUS_IDLE;

    // size is clamped to 1..MEM_DEPTH, a zero decimation factor means every word
    always_comb begin
        if (i_cmd_arg == '0) begin
            size_arg = iagc_pkg::ADDR_W'(1);
        end else if (i_cmd_arg > iagc_pkg::DATA_W'(MEM_DEPTH)) begin
            size_arg = iagc_pkg::ADDR_W'(MEM_DEPTH);
        end else begin
            size_arg = i_cmd_arg[iagc_pkg::ADDR_W-1:0];
        end
        dec_arg = i_cmd_arg[iagc_pkg::DEC_W-1:0];
        if (dec_arg == '0) begin
            dec_arg = iagc_pkg::DEC_W'(1);
        end
    end

    always_comb begin
        next_status = status;
        next_job    = job;
        if (job_done) begin  // a finishing job wins over a rejected command
            next_status = iagc_pkg::STATUS_IDLE;
            next_job    = iagc_pkg::STATUS_IDLE;
        end else if (reject) begin
            next_status = iagc_pkg::STATUS_CMD_ERROR;
        end else begin
            case (status)
                iagc_pkg::STATUS_RESET: next_status = iagc_pkg::STATUS_IDLE;
                iagc_pkg::STATUS_IDLE: begin
                    if (i_cmd_valid) begin
                        case (i_cmd)
                            iagc_pkg::OP_SAMPLE:  next_status = iagc_pkg::STATUS_SAMPLE;
                            iagc_pkg::OP_DUMP:    next_status = iagc_pkg::STATUS_DUMP_MEM;
                            iagc_pkg::OP_CLEAN:   next_status = iagc_pkg::STATUS_CLEAN_MEM;
                            iagc_pkg::OP_SET_MEM: next_status = iagc_pkg::STATUS_SET_MEM;
                            iagc_pkg::OP_SET_DEC: next_status = iagc_pkg::STATUS_SET_DEC;
                            default:              next_status = iagc_pkg::STATUS_IDLE;
                        endcase
                        if (i_cmd inside {iagc_pkg::OP_SAMPLE, iagc_pkg::OP_DUMP,
                                          iagc_pkg::OP_CLEAN}) begin
                            next_job = next_status;
                        end
                    end
                end
                iagc_pkg::STATUS_SET_MEM,
                iagc_pkg::STATUS_SET_DEC:   next_status = iagc_pkg::STATUS_IDLE;
                iagc_pkg::STATUS_CMD_ERROR: next_status = job;  // back to whatever was running
                default:                    next_status = status;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            status      <= iagc_pkg::STATUS_RESET;
            job         <= iagc_pkg::STATUS_IDLE;
            o_cmd_error <= 1'b0;
            o_mem_size  <= iagc_pkg::ADDR_W'(MEM_DEPTH);
            o_decimator <= iagc_pkg::DEC_W'(1);
        end else begin
            status      <= next_status;
            job         <= next_job;
            o_cmd_error <= reject;
            if (status == iagc_pkg::STATUS_IDLE && i_cmd_valid) begin
                if (i_cmd == iagc_pkg::OP_SET_MEM) begin
                    o_mem_size <= size_arg;
                end
                if (i_cmd == iagc_pkg::OP_SET_DEC) begin
                    o_decimator <= dec_arg;
                end
            end
        end
    end

    assign o_status = status;

endmodule

/* design/dac_sampler.sv */
`timescale 1ns/1ps

module dac_sampler #(
    parameter int END_HOLD = 4
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic [iagc_pkg::DATA_W-1:0] i_data,
    input  logic                        i_gate,
    input  iagc_pkg::iagc_status_e      i_status,
    input  logic [iagc_pkg::ADDR_W-1:0] i_memory_size,
    input  logic [iagc_pkg::DEC_W-1:0]  i_decimator,
    input  logic                        i_grant,
    output iagc_pkg::mem_req_t          o_req,
    output logic                        o_end,
    output logic                        o_done
);

    localparam int HOLD_W = $clog2(END_HOLD + 1);

    typedef enum logic [1:0] {
        S_INIT,
        S_WAIT,
        S_WRITE,
        S_END
    } state_e;

    state_e                      state;
    logic                        gate_q;
    logic                        rise;
    logic                        gated;
    logic                        capture;
    logic                        last_q;     // the last word has been captured
    logic [iagc_pkg::DEC_W-1:0]  dec_cnt;
    logic [iagc_pkg::DEC_W-1:0]  cnt_now;
    logic [iagc_pkg::ADDR_W-1:0] next_addr;
    logic [HOLD_W-1:0]           end_cnt;
    logic                        wr_valid;
    logic [iagc_pkg::ADDR_W-1:0] wr_addr;
    logic [iagc_pkg::DATA_W-1:0] wr_data;

    assign rise = i_gate && !gate_q;

    // the rising edge cycle is the first gated cycle of a burst
    assign gated   = !last_q && ((state == S_WAIT && rise) || (state == S_WRITE && i_gate));
    assign cnt_now = (state == S_WAIT) ? iagc_pkg::DEC_W'(1) : dec_cnt + 1'b1;
    assign capture = gated && cnt_now >= i_decimator;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= S_INIT;
            gate_q    <= 1'b0;
            dec_cnt   <= '0;
            next_addr <= '0;
            last_q    <= 1'b0;
            end_cnt   <= '0;
            wr_valid  <= 1'b0;
        end else begin
            gate_q <= i_gate;
            if (capture) begin
                wr_valid  <= 1'b1;
                next_addr <= next_addr + 1'b1;
                last_q    <= next_addr == i_memory_size - 1'b1;
            end else if (i_grant) begin
                wr_valid <= 1'b0;
            end
            if (gated) begin
                dec_cnt <= capture ? '0 : cnt_now;
            end
            case (state)
                S_INIT: begin
                    next_addr <= '0;
                    last_q    <= 1'b0;
                    end_cnt   <= '0;
                    if (i_status == iagc_pkg::STATUS_SAMPLE) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (rise) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (last_q) begin
                        state <= S_END;  // this cycle carries the last write
                    end else if (!i_gate) begin
                        state <= S_WAIT;
                    end
                end
                S_END: begin
                    end_cnt <= end_cnt + 1'b1;
                    if (end_cnt == HOLD_W'(END_HOLD - 1)) begin
                        state <= S_INIT;
                    end
                end
                default: state <= S_INIT;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (capture) begin
            wr_addr <= next_addr;
            wr_data <= i_data;
        end
    end

    assign o_req  = '{valid: wr_valid, we: 1'b1, addr: wr_addr, wdata: wr_data};
    assign o_end  = state == S_END;
    assign o_done = state == S_END && end_cnt == '0;

endmodule

/* design/mem_cleaner.sv */
`timescale 1ns/1ps

module mem_cleaner (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  iagc_pkg::iagc_status_e      i_status,
    input  logic [iagc_pkg::ADDR_W-1:0] i_memory_size,
    input  logic                        i_grant,
    output iagc_pkg::mem_req_t          o_req,
    output logic                        o_done
);

    logic                        busy;
    logic                        last;
    logic [iagc_pkg::ADDR_W-1:0] addr;

    assign last   = addr == i_memory_size - 1'b1;
    assign o_req  = '{valid: busy, we: 1'b1, addr: addr, wdata: '0};
    assign o_done = busy && i_grant && last;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (!busy) begin
            addr <= '0;
            busy <= i_status == iagc_pkg::STATUS_CLEAN_MEM;
        end else if (i_grant) begin  // only moves on when the write went out
            busy <= !last;
            addr <= addr + 1'b1;
        end
    end

endmodule

/* design/mem_dumper.sv */
`timescale 1ns/1ps

module mem_dumper (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  iagc_pkg::iagc_status_e      i_status,
    input  logic [iagc_pkg::ADDR_W-1:0] i_memory_size,
    input  logic                        i_grant,
    input  logic [iagc_pkg::DATA_W-1:0] i_rd_data,
    input  logic                        i_rd_valid,
    output iagc_pkg::mem_req_t          o_req,
    output iagc_pkg::dump_beat_t        o_dump,
    output logic                        o_done
);

    logic                        busy;
    logic                        issued_all;
    logic [iagc_pkg::ADDR_W-1:0] rd_addr;
    logic [iagc_pkg::ADDR_W-1:0] inflight_addr;  // address of the read now in the memory

    assign o_req  = '{valid: busy && !issued_all, we: 1'b0, addr: rd_addr, wdata: '0};
    assign o_dump = '{valid: i_rd_valid, addr: inflight_addr, data: i_rd_data};
    assign o_done = i_rd_valid && inflight_addr == i_memory_size - 1'b1;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            issued_all <= 1'b0;
            rd_addr    <= '0;
        end else if (!busy) begin
            rd_addr    <= '0;
            issued_all <= 1'b0;
            busy       <= i_status == iagc_pkg::STATUS_DUMP_MEM;
        end else begin
            if (i_grant) begin
                if (rd_addr == i_memory_size - 1'b1) begin
                    issued_all <= 1'b1;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
            if (o_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_grant) begin
            inflight_addr <= rd_addr;
        end
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  iagc_pkg::mem_req_t          i_sampler_req,
    input  iagc_pkg::mem_req_t          i_cleaner_req,
    input  iagc_pkg::mem_req_t          i_dumper_req,
    input  iagc_pkg::mem_req_t          i_host_req,
    input  logic [iagc_pkg::DATA_W-1:0] i_mem_rd_data,
    output logic                        o_sampler_grant,
    output logic                        o_cleaner_grant,
    output logic                        o_dumper_grant,
    output logic                        o_host_grant,
    output iagc_pkg::mem_req_t          o_mem_req,
    output logic                        o_dumper_rd_valid,
    output logic                        o_host_rd_valid,
    output logic [iagc_pkg::DATA_W-1:0] o_rd_data
);

    // sampler first since it has no way to wait
    always_comb begin
        o_sampler_grant = 1'b0;
        o_cleaner_grant = 1'b0;
        o_dumper_grant  = 1'b0;
        o_host_grant    = 1'b0;
        o_mem_req       = '0;
        if (i_sampler_req.valid) begin
            o_sampler_grant = 1'b1;
            o_mem_req       = i_sampler_req;
        end else if (i_cleaner_req.valid) begin
            o_cleaner_grant = 1'b1;
            o_mem_req       = i_cleaner_req;
        end else if (i_dumper_req.valid) begin
            o_dumper_grant = 1'b1;
            o_mem_req      = i_dumper_req;
        end else if (i_host_req.valid) begin
            o_host_grant = 1'b1;
            o_mem_req    = i_host_req;
        end
    end

    // owner of the read in flight, data returns the next cycle
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_dumper_rd_valid <= 1'b0;
            o_host_rd_valid   <= 1'b0;
        end else begin
            o_dumper_rd_valid <= o_dumper_grant && !i_dumper_req.we;
            o_host_rd_valid   <= o_host_grant && !i_host_req.we;
        end
    end

    assign o_rd_data = i_mem_rd_data;

endmodule

/* design/sample_memory.sv */
`timescale 1ns/1ps

module sample_memory #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                        i_clock,
    input  iagc_pkg::mem_req_t          i_req,
    output logic [iagc_pkg::DATA_W-1:0] o_rd_data
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [iagc_pkg::DATA_W-1:0] mem [MEM_DEPTH];
    logic [IDX_W-1:0]            idx;

    assign idx = i_req.addr[IDX_W-1:0];

    always_ff @(posedge i_clock) begin
        if (i_req.valid) begin
            if (i_req.we) begin
                mem[idx] <= i_req.wdata;
            end else begin
                o_rd_data <= mem[idx];  // read data holds until the next read
            end
        end
    end

endmodule

/* design/iagc_top.sv */
`timescale 1ns/1ps

module iagc_top #(
    parameter int MEM_DEPTH = 64,
    parameter int END_HOLD  = 4
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_cmd_valid,
    input  iagc_pkg::iagc_opcode_e      i_cmd,
    input  logic [iagc_pkg::DATA_W-1:0] i_cmd_arg,
    input  logic [iagc_pkg::DATA_W-1:0] i_data,
    input  logic                        i_gate,
    input  logic                        i_host_rd_en,
    input  logic [iagc_pkg::ADDR_W-1:0] i_host_rd_addr,
    output iagc_pkg::iagc_status_e      o_status,
    output logic                        o_cmd_error,
    output logic                        o_end,
    output iagc_pkg::dump_beat_t        o_dump,
    output logic                        o_host_rd_valid,
    output logic [iagc_pkg::DATA_W-1:0] o_host_rd_data
);

    logic [iagc_pkg::ADDR_W-1:0] mem_size;
    logic [iagc_pkg::DEC_W-1:0]  decimator;
    logic                        sample_done;
    logic                        clean_done;
    logic                        dump_done;
    iagc_pkg::mem_req_t          sampler_req;
    iagc_pkg::mem_req_t          cleaner_req;
    iagc_pkg::mem_req_t          dumper_req;
    iagc_pkg::mem_req_t          host_req;
    iagc_pkg::mem_req_t          mem_req;
    logic                        sampler_grant;
    logic                        cleaner_grant;
    logic                        dumper_grant;
    logic                        dumper_rd_valid;
    logic [iagc_pkg::DATA_W-1:0] mem_rd_data;
    logic [iagc_pkg::DATA_W-1:0] rd_data;

    // host keeps i_host_rd_en up until valid, so that cycle must not read again
    assign host_req = '{valid: i_host_rd_en && !o_host_rd_valid, we: 1'b0,
                        addr: i_host_rd_addr, wdata: '0};
    assign o_host_rd_data = rd_data;

    iagc_controller #(.MEM_DEPTH(MEM_DEPTH)) u_controller (
        .i_clock(i_clock), .i_rst_n(i_rst_n),
        .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .i_cmd_arg(i_cmd_arg),
        .i_sample_done(sample_done), .i_clean_done(clean_done), .i_dump_done(dump_done),
        .o_status(o_status), .o_mem_size(mem_size), .o_decimator(decimator),
        .o_cmd_error(o_cmd_error)
    );

    dac_sampler #(.END_HOLD(END_HOLD)) u_sampler (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_data(i_data), .i_gate(i_gate),
        .i_status(o_status), .i_memory_size(mem_size), .i_decimator(decimator),
        .i_grant(sampler_grant), .o_req(sampler_req), .o_end(o_end), .o_done(sample_done)
    );

    mem_cleaner u_cleaner (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_status(o_status),
        .i_memory_size(mem_size), .i_grant(cleaner_grant),
        .o_req(cleaner_req), .o_done(clean_done)
    );

    mem_dumper u_dumper (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_status(o_status),
        .i_memory_size(mem_size), .i_grant(dumper_grant),
        .i_rd_data(rd_data), .i_rd_valid(dumper_rd_valid),
        .o_req(dumper_req), .o_dump(o_dump), .o_done(dump_done)
    );

    mem_arbiter u_arbiter (
        .i_clock(i_clock), .i_rst_n(i_rst_n),
        .i_sampler_req(sampler_req), .i_cleaner_req(cleaner_req),
        .i_dumper_req(dumper_req), .i_host_req(host_req), .i_mem_rd_data(mem_rd_data),
        .o_sampler_grant(sampler_grant), .o_cleaner_grant(cleaner_grant),
        .o_dumper_grant(dumper_grant), .o_host_grant(),
        .o_mem_req(mem_req), .o_dumper_rd_valid(dumper_rd_valid),
        .o_host_rd_valid(o_host_rd_valid), .o_rd_data(rd_data)
    );

    sample_memory #(.MEM_DEPTH(MEM_DEPTH)) u_memory (
        .i_clock(i_clock), .i_req(mem_req), .o_rd_data(mem_rd_data)
    );

endmodule

/* tests/tb_iagc_top.sv */
`timescale 1ns/1ps

module tb_iagc_top;

    localparam int MEM_DEPTH = 64;
    localparam int END_HOLD  = 4;
    localparam int N_STEPS   = 10;

    typedef struct packed {
        iagc_pkg::iagc_opcode_e op;
        logic [15:0]            arg;
        logic [7:0]             gate_len;  // gated cycles before the gap
        logic                   host_rd;   // random host reads while dumping
    } step_t;

    logic                        i_clock;
    logic                        i_rst_n;
    logic                        i_cmd_valid;
    iagc_pkg::iagc_opcode_e      i_cmd;
    logic [iagc_pkg::DATA_W-1:0] i_cmd_arg;
    logic [iagc_pkg::DATA_W-1:0] i_data;
    logic                        i_gate;
    logic                        i_host_rd_en;
    logic [iagc_pkg::ADDR_W-1:0] i_host_rd_addr;
    iagc_pkg::iagc_status_e      o_status;
    logic                        o_cmd_error;
    logic                        o_end;
    iagc_pkg::dump_beat_t        o_dump;
    logic                        o_host_rd_valid;
    logic [iagc_pkg::DATA_W-1:0] o_host_rd_data;

    step_t                       steps [N_STEPS];
    logic [iagc_pkg::DATA_W-1:0] model_mem [MEM_DEPTH];
    iagc_pkg::dump_beat_t        exp_beat;
    int                          cur_size;
    int                          cur_dec;
    int                          errors;
    int                          checks;
    int                          seed;
    int                          limit_cycles = 0;
    int                          run_cnt;
    int                          cap_count;
    int                          beat_idx;
    logic                        sampling;
    logic                        dumping;
    logic                        seen_end;
    logic                        gate_prev;

    iagc_top #(.MEM_DEPTH(MEM_DEPTH), .END_HOLD(END_HOLD)) u_iagc_top (
        .i_clock(i_clock), .i_rst_n(i_rst_n),
        .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .i_cmd_arg(i_cmd_arg),
        .i_data(i_data), .i_gate(i_gate),
        .i_host_rd_en(i_host_rd_en), .i_host_rd_addr(i_host_rd_addr),
        .o_status(o_status), .o_cmd_error(o_cmd_error), .o_end(o_end), .o_dump(o_dump),
        .o_host_rd_valid(o_host_rd_valid), .o_host_rd_data(o_host_rd_data)
    );

    initial i_clock = 1'b0;
    always #5 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        i_data <= i_data + 1'b1;  // sample source is a free running counter
    end

    // every cur_dec-th gated cycle counted from each rising edge is stored
    always @(negedge i_clock) begin
        if (sampling && i_gate && cap_count < cur_size) begin
            run_cnt = gate_prev ? run_cnt + 1 : 1;
            if (run_cnt == cur_dec) begin
                model_mem[cap_count] = i_data;
                cap_count            = cap_count + 1;
                run_cnt              = 0;
            end
        end
        gate_prev = i_gate;
        if (o_end && o_status != iagc_pkg::STATUS_IDLE) begin
            seen_end = 1'b1;
        end
    end

    always @(negedge i_clock) begin
        if (o_dump.valid) begin
            if (!dumping || beat_idx >= cur_size) begin
                $display("dump beat at %0t arrived when no dump expected one", $time);
                errors = errors + 1;
            end else begin
                exp_beat.valid = 1'b1;
                exp_beat.addr  = iagc_pkg::ADDR_W'(beat_idx);
                exp_beat.data  = model_mem[beat_idx];
                check_beat(o_dump, exp_beat, "dump beat");
                beat_idx = beat_idx + 1;
            end
        end
    end

    function automatic int size_rule(input int arg);
        if (arg == 0) begin
            return 1;
        end
        if (arg > MEM_DEPTH) begin
            return MEM_DEPTH;
        end
        return arg;
    endfunction

    function automatic int dec_rule(input int arg);
        return (arg % 16 == 0) ? 1 : arg % 16;  // only the low four bits are kept
    endfunction

    task automatic check_status(input iagc_pkg::iagc_status_e got,
                                input iagc_pkg::iagc_status_e exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR %0t: %s status %s, expected %s", $time, what, got.name(), exp.name());
            errors = errors + 1;
        end
    endtask

    task automatic check_beat(input iagc_pkg::dump_beat_t got,
                              input iagc_pkg::dump_beat_t exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR %0t: %s got addr %0d data %h, expected addr %0d data %h",
                     $time, what, got.addr, got.data, exp.addr, exp.data);
            errors = errors + 1;
        end
    endtask

    task automatic check_word(input logic [iagc_pkg::DATA_W-1:0] got,
                              input logic [iagc_pkg::DATA_W-1:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic send_cmd(input iagc_pkg::iagc_opcode_e op, input int arg);
        @(posedge i_clock);
        i_cmd_valid <= 1'b1;
        i_cmd       <= op;
        i_cmd_arg   <= iagc_pkg::DATA_W'(arg);
        @(posedge i_clock);
        i_cmd_valid <= 1'b0;
        i_cmd       <= iagc_pkg::OP_NOP;
    endtask

    task automatic wait_idle(input int max_cycles, input string what);
        int n;
        n = 0;
        while (o_status != iagc_pkg::STATUS_IDLE && n < max_cycles) begin
            @(negedge i_clock);
            n = n + 1;
        end
        if (o_status != iagc_pkg::STATUS_IDLE) begin
            $display("%s did not bring the status back to IDLE in %0d cycles", what, n);
            errors = errors + 1;
        end
    endtask

    task automatic host_read();
        logic [iagc_pkg::ADDR_W-1:0] addr;
        int                          n;
        addr = iagc_pkg::ADDR_W'({$random(seed)} % cur_size);
        n    = 0;
        @(posedge i_clock);
        i_host_rd_en   <= 1'b1;
        i_host_rd_addr <= addr;
        @(negedge i_clock);
        while (!o_host_rd_valid && n < cur_size * 4 + 50) begin
            @(negedge i_clock);
            n = n + 1;
        end
        if (!o_host_rd_valid) begin
            $display("host read of address %0d never returned data", addr);
            errors = errors + 1;
        end else begin
            check_word(o_host_rd_data, model_mem[addr], "host read");
        end
        @(posedge i_clock);
        i_host_rd_en <= 1'b0;
    endtask

    task automatic run_sample(input int gate_len);
        seen_end  = 1'b0;
        cap_count = 0;
        run_cnt   = 0;
        send_cmd(iagc_pkg::OP_SAMPLE, 0);
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_SAMPLE, "sample start");
        repeat (2) @(posedge i_clock);  // sampler is waiting for the gate by now
        sampling = 1'b1;
        i_gate <= 1'b1;
        repeat (gate_len) @(posedge i_clock);
        i_gate <= 1'b0;
        send_cmd(iagc_pkg::OP_CLEAN, 0);  // must be rejected while sampling
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_CMD_ERROR, "busy command");
        check_flag(o_cmd_error, 1'b1, "o_cmd_error on busy command");
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_SAMPLE, "after rejected command");
        check_flag(o_cmd_error, 1'b0, "o_cmd_error after its pulse");
        @(posedge i_clock);
        i_gate <= 1'b1;
        @(negedge i_clock);
        wait_idle(cur_size * cur_dec * 4 + 100, "sampling");
        @(posedge i_clock);
        i_gate   <= 1'b0;
        sampling = 1'b0;
        if (!seen_end) begin
            $display("o_end was never seen before the sampler finished");
            errors = errors + 1;
        end
        if (cap_count != cur_size) begin
            $display("sampler finished after %0d of %0d words", cap_count, cur_size);
            errors = errors + 1;
        end
    endtask

    task automatic run_dump(input logic host_rd);
        beat_idx = 0;
        dumping  = 1'b1;
        send_cmd(iagc_pkg::OP_DUMP, 0);
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_DUMP_MEM, "dump start");
        if (host_rd) begin
            fork
                wait_idle(cur_size * 4 + 100, "dump");
                repeat (4) host_read();
            join
        end else begin
            wait_idle(cur_size * 4 + 100, "dump");
        end
        dumping = 1'b0;
        if (beat_idx != cur_size) begin
            $display("dump delivered %0d beats instead of %0d", beat_idx, cur_size);
            errors = errors + 1;
        end
    endtask

    task automatic run_step(input step_t st);
        case (st.op)
            iagc_pkg::OP_SET_MEM: begin
                send_cmd(st.op, st.arg);
                @(negedge i_clock);
                check_status(o_status, iagc_pkg::STATUS_SET_MEM, "set size");
                @(negedge i_clock);
                check_status(o_status, iagc_pkg::STATUS_IDLE, "after set size");
                cur_size = size_rule(st.arg);
            end
            iagc_pkg::OP_SET_DEC: begin
                send_cmd(st.op, st.arg);
                @(negedge i_clock);
                check_status(o_status, iagc_pkg::STATUS_SET_DEC, "set decimator");
                @(negedge i_clock);
                check_status(o_status, iagc_pkg::STATUS_IDLE, "after set decimator");
                cur_dec = dec_rule(st.arg);
            end
            iagc_pkg::OP_SAMPLE: run_sample(st.gate_len);
            iagc_pkg::OP_DUMP:   run_dump(st.host_rd);
            iagc_pkg::OP_CLEAN: begin
                send_cmd(st.op, 0);
                @(negedge i_clock);
                check_status(o_status, iagc_pkg::STATUS_CLEAN_MEM, "clean start");
                wait_idle(cur_size * 4 + 100, "clean");
                for (int a = 0; a < cur_size; a++) begin
                    model_mem[a] = '0;
                end
            end
            default: send_cmd(st.op, st.arg);
        endcase
    endtask

    initial begin
        int sz;
        int dc;
        seed           = 32'h1b6e36cd;
        errors         = 0;
        checks         = 0;
        i_rst_n        = 1'b0;
        i_cmd_valid    = 1'b0;
        i_cmd          = iagc_pkg::OP_NOP;
        i_cmd_arg      = '0;
        i_data         = '0;
        i_gate         = 1'b0;
        i_host_rd_en   = 1'b0;
        i_host_rd_addr = '0;
        sampling       = 1'b0;
        dumping        = 1'b0;
        seen_end       = 1'b0;
        gate_prev      = 1'b0;
        run_cnt        = 0;
        cap_count      = 0;
        beat_idx       = 0;
        cur_size       = MEM_DEPTH;
        cur_dec        = 1;

        // opcode, argument, first gate burst, host reads
        steps[0] = '{iagc_pkg::OP_SET_MEM, 16'd16, 8'd0,  1'b0};
        steps[1] = '{iagc_pkg::OP_SET_DEC, 16'd3,  8'd0,  1'b0};
        steps[2] = '{iagc_pkg::OP_SAMPLE,  16'd0,  8'd10, 1'b0};
        steps[3] = '{iagc_pkg::OP_DUMP,    16'd0,  8'd0,  1'b1};
        steps[4] = '{iagc_pkg::OP_CLEAN,   16'd0,  8'd0,  1'b0};
        steps[5] = '{iagc_pkg::OP_DUMP,    16'd0,  8'd0,  1'b0};
        steps[6] = '{iagc_pkg::OP_SET_MEM, 16'd8,  8'd0,  1'b0};
        steps[7] = '{iagc_pkg::OP_SET_DEC, 16'd0,  8'd0,  1'b0};
        steps[8] = '{iagc_pkg::OP_SAMPLE,  16'd0,  8'd5,  1'b0};
        steps[9] = '{iagc_pkg::OP_DUMP,    16'd0,  8'd0,  1'b1};

        sz = MEM_DEPTH;
        dc = 1;
        for (int k = 0; k < N_STEPS; k++) begin
            if (steps[k].op == iagc_pkg::OP_SET_MEM) begin
                sz = size_rule(steps[k].arg);
            end
            if (steps[k].op == iagc_pkg::OP_SET_DEC) begin
                dc = dec_rule(steps[k].arg);
            end
            limit_cycles = limit_cycles + sz * dc * 4;
        end
        limit_cycles = limit_cycles + 200;

        repeat (5) @(posedge i_clock);
        i_rst_n <= 1'b1;
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_RESET, "first cycle after reset");
        @(negedge i_clock);
        check_status(o_status, iagc_pkg::STATUS_IDLE, "after reset");
        check_flag(o_dump.valid, 1'b0, "o_dump.valid after reset");
        check_flag(o_host_rd_valid, 1'b0, "o_host_rd_valid after reset");
        check_flag(o_cmd_error, 1'b0, "o_cmd_error after reset");

        for (int k = 0; k < N_STEPS; k++) begin
            run_step(steps[k]);
        end
        repeat (5) @(posedge i_clock);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge i_clock);
        $display("watchdog expired after %0d cycles before the tests finished", limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* list.f */
design/iagc_pkg.sv
design/iagc_controller.sv
design/dac_sampler.sv
design/mem_cleaner.sv
design/mem_dumper.sv
design/mem_arbiter.sv
design/sample_memory.sv
design/iagc_top.sv
tests/tb_iagc_top.sv

/* Bender.yml */
package:
  name: iagc

sources:
  # package first, then the blocks, then the top level
  - design/iagc_pkg.sv
  - design/iagc_controller.sv
  - design/dac_sampler.sv
  - design/mem_cleaner.sv
  - design/mem_dumper.sv
  - design/mem_arbiter.sv
  - design/sample_memory.sv
  - design/iagc_top.sv
  - target: test
    files:
      - tests/tb_iagc_top.sv
